/* src/fifo_pkg.sv */
package fifo_pkg;

    // entries per stage, power of two
    localparam int DEPTH = 4;

    localparam int ADDR_W = $clog2(DEPTH);

    // one extra wrap bit tells full from empty
    localparam int PTR_W = ADDR_W + 1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W-1:0]  ptr_t;

    // defaults for the chain top level
    localparam int DEFAULT_W = 16;
    localparam int DEFAULT_N = 2;

endpackage

/* src/cdc_pkg.sv */
package cdc_pkg;

    // flops per synchronizer chain
    localparam int SYNC_STAGES = 2;

    // pointer to gray, only one bit flips per increment
    function automatic fifo_pkg::ptr_t bin_to_gray(input fifo_pkg::ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // gray back to binary, fold down from the msb
    function automatic fifo_pkg::ptr_t gray_to_bin(input fifo_pkg::ptr_t gray);
        fifo_pkg::ptr_t bin;
        bin[fifo_pkg::PTR_W-1] = gray[fifo_pkg::PTR_W-1];
        for (int i = fifo_pkg::PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* src/cdc_sync.sv */
`timescale 1ns/1ps

module cdc_sync #(
    parameter int               WIDTH       = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] async_in,
    output logic [WIDTH-1:0] sync_out
);
    // stage 0 is the metastable capture flop
    logic [WIDTH-1:0] sync_q [cdc_pkg::SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < cdc_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= RESET_VALUE;
            end
        end else begin
            sync_q[0] <= async_in;
            for (int i = 1; i < cdc_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_out = sync_q[cdc_pkg::SYNC_STAGES-1];

endmodule

/* src/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
    parameter int W = fifo_pkg::DEFAULT_W
) (
    input  logic         rst_n,

    input  logic         w_clk,
    input  logic         w_trigger,
    input  logic [W-1:0] w_data,
    output logic         w_ready,

    input  logic         r_clk,
    input  logic         r_trigger,
    output logic [W-1:0] r_data,
    output logic         r_ready
);
    typedef logic [W-1:0] word_t;

    word_t mem [fifo_pkg::DEPTH];

    // write domain pointers
    fifo_pkg::ptr_t w_bin;
    fifo_pkg::ptr_t w_bin_next;
    fifo_pkg::ptr_t w_gray;
    fifo_pkg::ptr_t r_gray_sync;
    fifo_pkg::ptr_t r_bin_sync;
    fifo_pkg::addr_t w_addr;
    logic w_push;
    logic w_full_next;

    // read domain pointers
    fifo_pkg::ptr_t r_bin;
    fifo_pkg::ptr_t r_bin_next;
    fifo_pkg::ptr_t r_gray;
    fifo_pkg::ptr_t w_gray_sync;
    fifo_pkg::ptr_t w_bin_sync;
    fifo_pkg::addr_t r_addr;
    logic r_pop;
    logic r_empty_next;

    // a trigger only counts while the matching ready is high
    assign w_push = w_trigger & w_ready;
    assign r_pop  = r_trigger & r_ready;

    assign w_bin_next = w_bin + fifo_pkg::ptr_t'(w_push);
    assign r_bin_next = r_bin + fifo_pkg::ptr_t'(r_pop);

    assign w_addr = w_bin[fifo_pkg::ADDR_W-1:0];
    assign r_addr = r_bin[fifo_pkg::ADDR_W-1:0];

    always_ff @(posedge w_clk) begin
        if (w_push) begin
            mem[w_addr] <= w_data;
        end
    end

    // full when the write pointer is one lap ahead of the synced read pointer
    assign r_bin_sync  = cdc_pkg::gray_to_bin(r_gray_sync);
    assign w_full_next =
        (w_bin_next[fifo_pkg::PTR_W-1] != r_bin_sync[fifo_pkg::PTR_W-1]) &&
        (w_bin_next[fifo_pkg::PTR_W-2:0] == r_bin_sync[fifo_pkg::PTR_W-2:0]);

    always_ff @(posedge w_clk) begin
        if (!rst_n) begin
            w_bin   <= '0;
            w_gray  <= '0;
            w_ready <= 1'b1;
        end else begin
            w_bin   <= w_bin_next;
            w_gray  <= cdc_pkg::bin_to_gray(w_bin_next);
            w_ready <= !w_full_next;
        end
    end

    // empty when the read pointer has caught up with the synced write pointer
    assign w_bin_sync   = cdc_pkg::gray_to_bin(w_gray_sync);
    assign r_empty_next = (r_bin_next == w_bin_sync);

    always_ff @(posedge r_clk) begin
        if (!rst_n) begin
            r_bin   <= '0;
            r_gray  <= '0;
            r_ready <= 1'b0;
        end else begin
            r_bin   <= r_bin_next;
            r_gray  <= cdc_pkg::bin_to_gray(r_bin_next);
            r_ready <= !r_empty_next;
        end
    end

    // fall-through head, follows the read pointer directly
    assign r_data = mem[r_addr];

    cdc_sync #(
        .WIDTH       (fifo_pkg::PTR_W),
        .RESET_VALUE ('0)
    ) u_r_gray_sync (
        .clk      (w_clk),
        .rst_n    (rst_n),
        .async_in (r_gray),
        .sync_out (r_gray_sync)
    );

    cdc_sync #(
        .WIDTH       (fifo_pkg::PTR_W),
        .RESET_VALUE ('0)
    ) u_w_gray_sync (
        .clk      (r_clk),
        .rst_n    (rst_n),
        .async_in (w_gray),
        .sync_out (w_gray_sync)
    );

endmodule

/* src/async_fifo_chain.sv */
`timescale 1ns/1ps

module async_fifo_chain #(
    parameter int W = fifo_pkg::DEFAULT_W,
    parameter int N = fifo_pkg::DEFAULT_N
) (
    input  logic         rst_n,
    // must be the faster of w_clk and r_clk
    input  logic         prop_clk,

    input  logic         w_clk,
    input  logic         w_trigger,
    input  logic [W-1:0] w_data,
    output logic [N-1:0] w_ready,
    output logic         w_half_empty,

    input  logic         r_clk,
    input  logic         r_trigger,
    output logic [W-1:0] r_data,
    output logic [N-1:0] r_ready,
    output logic         r_half_full
);
    localparam int MID_LEFT  = N / 2 - 1;
    localparam int MID_RIGHT = N / 2;

    logic [N-1:0] stage_w_clk;
    logic [N-1:0] stage_r_clk;
    logic [N-1:0] stage_w_trigger;
    logic [N-1:0] stage_r_trigger;
    logic [W-1:0] stage_w_data [N];
    logic [W-1:0] stage_r_data [N];

    logic half_empty_async;
    logic half_full_async;

    if ((N < 2) || (N % 2 != 0)) begin : g_bad_n
        $error("async_fifo_chain: N must be even and at least 2");
    end

    for (genvar i = 0; i < N; i++) begin : g_stage
        // first stage faces the writer, the rest are fed by the previous stage
        if (i == 0) begin : g_head
            assign stage_w_clk[i]     = w_clk;
            assign stage_w_trigger[i] = w_trigger;
            assign stage_w_data[i]    = w_data;
        end else begin : g_link_in
            assign stage_w_clk[i]     = prop_clk;
            assign stage_w_trigger[i] = r_ready[i-1];
            assign stage_w_data[i]    = stage_r_data[i-1];
        end

        // a stage drains whenever the next one has room
        if (i == N - 1) begin : g_tail
            assign stage_r_clk[i]     = r_clk;
            assign stage_r_trigger[i] = r_trigger;
        end else begin : g_link_out
            assign stage_r_clk[i]     = prop_clk;
            assign stage_r_trigger[i] = w_ready[i+1];
        end

        async_fifo #(
            .W (W)
        ) u_async_fifo (
            .rst_n     (rst_n),
            .w_clk     (stage_w_clk[i]),
            .w_trigger (stage_w_trigger[i]),
            .w_data    (stage_w_data[i]),
            .w_ready   (w_ready[i]),
            .r_clk     (stage_r_clk[i]),
            .r_trigger (stage_r_trigger[i]),
            .r_data    (stage_r_data[i]),
            .r_ready   (r_ready[i])
        );
    end

    assign r_data = stage_r_data[N-1];

    // left half empty means the middle-left stage has nothing to offer
    assign half_empty_async = !r_ready[MID_LEFT];
    // right half full means the middle-right stage takes no more
    assign half_full_async  = !w_ready[MID_RIGHT];

    cdc_sync #(
        .WIDTH       (1),
        .RESET_VALUE (1'b1)
    ) u_half_empty_sync (
        .clk      (w_clk),
        .rst_n    (rst_n),
        .async_in (half_empty_async),
        .sync_out (w_half_empty)
    );

    cdc_sync #(
        .WIDTH       (1),
        .RESET_VALUE (1'b0)
    ) u_half_full_sync (
        .clk      (r_clk),
        .rst_n    (rst_n),
        .async_in (half_full_async),
        .sync_out (r_half_full)
    );

endmodule

/* verification/fifo_chain_assert.sv */
`timescale 1ns/1ps

module fifo_chain_assert (
    input logic           rst_n,
    input logic           w_clk,
    input logic           r_clk,
    input logic           w_ready,
    input logic           r_ready,
    input fifo_pkg::ptr_t w_bin,
    input fifo_pkg::ptr_t w_gray,
    input fifo_pkg::ptr_t r_bin,
    input fifo_pkg::ptr_t r_gray
);
    // failures seen by this stage, summed up by the testbench
    int unsigned error_count = 0;

    // a full stage must not advance its write pointer
    write_holds_when_full: assert property (@(posedge w_clk) disable iff (!rst_n)
        !w_ready |=> $stable(w_bin))
        else begin
            error_count++;
            $error("write pointer moved while the stage was full");
        end

    // an empty stage must not advance its read pointer
    read_holds_when_empty: assert property (@(posedge r_clk) disable iff (!rst_n)
        !r_ready |=> $stable(r_bin))
        else begin
            error_count++;
            $error("read pointer moved while the stage was empty");
        end

    // gray pointers cross domains, so at most one bit may flip per edge
    write_gray_one_bit: assert property (@(posedge w_clk) disable iff (!rst_n)
        $past(rst_n) |-> $countones(w_gray ^ $past(w_gray)) <= 1)
        else begin
            error_count++;
            $error("write gray pointer flipped more than one bit");
        end

    read_gray_one_bit: assert property (@(posedge r_clk) disable iff (!rst_n)
        $past(rst_n) |-> $countones(r_gray ^ $past(r_gray)) <= 1)
        else begin
            error_count++;
            $error("read gray pointer flipped more than one bit");
        end

endmodule

bind async_fifo fifo_chain_assert u_fifo_chain_assert (
    .rst_n   (rst_n),
    .w_clk   (w_clk),
    .r_clk   (r_clk),
    .w_ready (w_ready),
    .r_ready (r_ready),
    .w_bin   (w_bin),
    .w_gray  (w_gray),
    .r_bin   (r_bin),
    .r_gray  (r_gray)
);

/* verification/fifo_chain_tb.sv */
`timescale 1ns/1ps

module fifo_chain_tb;

    localparam int W            = 16;
    localparam int N            = 4;
    localparam int W_PERIOD     = 4;
    localparam int R_PERIOD     = 8;
    localparam int CAPACITY     = N * fifo_pkg::DEPTH;
    localparam int RANDOM_WORDS = 300;
    localparam int LOW_HOLD_NS  = 100;
    localparam int BLOCKED      = 10;
    // random reads average two read cycles each, three leaves headroom
    localparam int TEST_NS      = R_PERIOD * (3 * RANDOM_WORDS + 4 * CAPACITY)
                                  + LOW_HOLD_NS + 2 * R_PERIOD * BLOCKED;
    localparam int WATCHDOG_NS  = TEST_NS + 2000;

    logic         rst_n;
    logic         prop_clk;
    logic         w_clk;
    logic         w_trigger;
    logic [W-1:0] w_data;
    logic [N-1:0] w_ready;
    logic         w_half_empty;
    logic         r_clk;
    logic         r_trigger;
    logic [W-1:0] r_data;
    logic [N-1:0] r_ready;
    logic         r_half_full;

    logic [W-1:0] sb [$];
    logic [15:0]  lfsr_state = 16'd82;
    int           write_count = 0;
    int           read_count = 0;
    int           check_errors = 0;
    int           errors_at_start = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;
    string        test_name = "reset";
    int unsigned  bound_errors [N];

    async_fifo_chain #(
        .W (W),
        .N (N)
    ) u_async_fifo_chain (
        .rst_n        (rst_n),
        .prop_clk     (prop_clk),
        .w_clk        (w_clk),
        .w_trigger    (w_trigger),
        .w_data       (w_data),
        .w_ready      (w_ready),
        .w_half_empty (w_half_empty),
        .r_clk        (r_clk),
        .r_trigger    (r_trigger),
        .r_data       (r_data),
        .r_ready      (r_ready),
        .r_half_full  (r_half_full)
    );

    // failure counts of the assertion module bound into each stage
    for (genvar i = 0; i < N; i++) begin : g_assert_tap
        assign bound_errors[i] =
            u_async_fifo_chain.g_stage[i].u_async_fifo.u_fifo_chain_assert.error_count;
    end

    initial begin
        prop_clk = 1'b0;
        forever #2 prop_clk = ~prop_clk;
    end

    // w_clk lags prop_clk by 1 ns, r_clk edges fall between the input drive points
    initial begin
        w_clk = 1'b0;
        #1;
        forever #(W_PERIOD / 2) w_clk = ~w_clk;
    end

    initial begin
        r_clk = 1'b0;
        #1;
        forever #(R_PERIOD / 2) r_clk = ~r_clk;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int count, output logic [W-1:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int total_errors();
        int sum;
        sum = check_errors;
        for (int i = 0; i < N; i++) begin
            sum += int'(bound_errors[i]);
        end
        return sum;
    endfunction

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected,
                     actual);
            check_errors++;
        end
    endtask

    // sampled on the falling edge, where the values for the next rising edge are settled
    always @(negedge w_clk) begin
        if (rst_n && w_trigger && w_ready[0]) begin
            sb.push_back(w_data);
            write_count++;
        end
    end

    always @(negedge r_clk) begin : read_monitor
        logic [W-1:0] expected;
        if (rst_n && r_trigger && r_ready[N-1]) begin
            read_count++;
            assert (sb.size() != 0) else begin
                $display("%s: a word was read that was never written", test_name);
                check_errors++;
            end
            if (sb.size() != 0) begin
                expected = sb.pop_front();
                assert (r_data == expected) else begin
                    $display("FAILED %s r_data: expected %h, actual %h", test_name,
                             expected, r_data);
                    check_errors++;
                end
            end
        end
    end

    task automatic write_words(input int count);
        int sent;
        logic [W-1:0] value;
        sent = 0;
        @(posedge w_clk);
        #1;
        while (sent < count) begin
            take_bits(W, value);
            w_data = value;
            w_trigger = 1'b1;
            @(negedge w_clk);
            while (!w_ready[0]) begin
                @(negedge w_clk);
            end
            @(posedge w_clk);
            #1;
            sent++;
        end
        w_trigger = 1'b0;
    endtask

    // keep offering words until w_ready[0] has stayed low for hold_ns
    task automatic fill_chain(input int hold_ns);
        int low_ns;
        logic [W-1:0] value;
        low_ns = 0;
        @(posedge w_clk);
        #1;
        take_bits(W, value);
        w_data = value;
        w_trigger = 1'b1;
        while (low_ns < hold_ns) begin
            @(negedge w_clk);
            if (w_ready[0]) begin
                low_ns = 0;
                @(posedge w_clk);
                #1;
                take_bits(W, value);
                w_data = value;
            end else begin
                low_ns += W_PERIOD;
            end
        end
        @(posedge w_clk);
        #1;
        w_trigger = 1'b0;
    endtask

    task automatic read_random(input int target);
        logic [W-1:0] bit_value;
        while (read_count < target) begin
            @(posedge r_clk);
            #1;
            take_bits(1, bit_value);
            r_trigger = bit_value[0];
        end
        r_trigger = 1'b0;
    endtask

    task automatic drain_chain();
        @(posedge r_clk);
        #1;
        r_trigger = 1'b1;
        wait (sb.size() == 0);
        @(posedge r_clk);
        #1;
        r_trigger = 1'b0;
        @(negedge r_clk);
        check_equal("r_ready after drain", 0, int'(r_ready[N-1]));
    endtask

    task automatic hold_blocked_reads(input int cycles);
        @(posedge r_clk);
        #1;
        r_trigger = 1'b1;
        repeat (cycles) begin
            @(negedge r_clk);
            check_equal("r_ready while empty", 0, int'(r_ready[N-1]));
        end
        @(posedge r_clk);
        #1;
        r_trigger = 1'b0;
    endtask

    // new data every cycle, none of it may enter the full chain
    task automatic hold_blocked_writes(input int cycles);
        logic [W-1:0] value;
        @(posedge w_clk);
        #1;
        w_trigger = 1'b1;
        repeat (cycles) begin
            take_bits(W, value);
            w_data = value;
            @(negedge w_clk);
            check_equal("w_ready while full", 0, int'(w_ready[0]));
            @(posedge w_clk);
            #1;
        end
        w_trigger = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
    endtask

    task automatic finish_test();
        int errors;
        errors = total_errors() - errors_at_start;
        if (errors == 0) begin
            tests_ok++;
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, errors);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
        $display("Test failed");
        $finish;
    end

    initial begin
        int writes_before;
        int reads_before;
        rst_n = 1'b0;
        w_trigger = 1'b0;
        w_data = '0;
        r_trigger = 1'b0;
        repeat (3) @(posedge prop_clk);
        @(posedge w_clk);
        #1;
        rst_n = 1'b1;

        start_test("reset_levels");
        @(negedge w_clk);
        check_equal("w_ready", (1 << N) - 1, int'(w_ready));
        check_equal("r_ready", 0, int'(r_ready));
        check_equal("w_half_empty", 1, int'(w_half_empty));
        check_equal("r_half_full", 0, int'(r_half_full));
        finish_test();

        start_test("fill");
        writes_before = write_count;
        fill_chain(LOW_HOLD_NS);
        check_equal("accepted writes", CAPACITY, write_count - writes_before);
        check_equal("r_half_full", 1, int'(r_half_full));
        check_equal("w_half_empty", 0, int'(w_half_empty));
        finish_test();

        start_test("drain");
        reads_before = read_count;
        drain_chain();
        check_equal("words drained", CAPACITY, read_count - reads_before);
        repeat (cdc_pkg::SYNC_STAGES + 2) @(negedge w_clk);
        check_equal("w_half_empty", 1, int'(w_half_empty));
        finish_test();

        start_test("random_stream");
        fork
            write_words(RANDOM_WORDS);
            read_random(read_count + RANDOM_WORDS);
        join
        check_equal("words left over", 0, sb.size());
        // a duplicated word would still sit somewhere in the chain
        repeat (4 * N) @(negedge r_clk);
        check_equal("r_ready after stream", 0, int'(r_ready));
        finish_test();

        start_test("blocked_triggers");
        reads_before = read_count;
        hold_blocked_reads(BLOCKED);
        check_equal("reads while empty", reads_before, read_count);
        fill_chain(LOW_HOLD_NS);
        writes_before = write_count;
        hold_blocked_writes(BLOCKED);
        check_equal("writes while full", writes_before, write_count);
        check_equal("words held", CAPACITY, sb.size());
        drain_chain();
        check_equal("words drained", CAPACITY, read_count - reads_before);
        finish_test();

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/fifo_pkg.sv
src/cdc_pkg.sv
src/cdc_sync.sv
src/async_fifo.sv
src/async_fifo_chain.sv
verification/fifo_chain_assert.sv
verification/fifo_chain_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := fifo_chain_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
